// File: hw/icache_cfg_pkg.sv
`default_nettype none

package icache_cfg_pkg;

    //////////////////////////////////////////////////
    // cache geometry

    // defaults only, the top level passes its own values down
    localparam int INDEX_WIDTH  = 4;  // 16 sets
    localparam int OFFSET_WIDTH = 2;  // byte offset inside the word

    // one 32-bit word per line, so a set holds two words

    //////////////////////////////////////////////////
    // widths with a meaning

    typedef logic [31:0] word_t;  // instruction or data word
    typedef logic [31:0] addr_t;  // byte address from the pipeline

    // tag width is derived in each module from the two widths above

endpackage

`default_nettype wire

// File: hw/icache_op_pkg.sv
`default_nettype none

package icache_op_pkg;

    //////////////////////////////////////////////////
    // pipeline side

    typedef struct packed {
        icache_cfg_pkg::addr_t addr;
        logic                  is_op;     // cache operation, not a fetch
        icache_cfg_pkg::word_t opcode;    // only looked at when is_op
        logic                  uncached;
    } fetch_req_t;

    typedef struct packed {
        logic flush;
        logic stall;  // bit 0
    } pipe_ctrl_t;

    typedef enum logic [2:0] {
        OP_NONE,
        OP_IDX_INIT,
        OP_IDX_INV,
        OP_HIT_INV,
        OP_IBAR
    } cacop_kind_e;

    //////////////////////////////////////////////////
    // control inside the cache

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_MISS_WAIT,
        ST_OPERATION,
        ST_FLUSH
    } fsm_state_e;

    typedef struct packed {
        logic [1:0] inval;        // clear valid of these ways at the index
        logic       init_en;
        logic       init_way;
        logic       ibar;         // drop every line
        logic [1:0] fill_way_we;  // refill writes tag and sets valid
    } tagv_cmd_t;

endpackage

`default_nettype wire

// File: hw/icache_req_decode.sv
`timescale 1ns/1ps
`default_nettype none

module icache_req_decode #(
    parameter int INDEX_WIDTH  = icache_cfg_pkg::INDEX_WIDTH,
    parameter int OFFSET_WIDTH = icache_cfg_pkg::OFFSET_WIDTH,
    localparam int TAG_WIDTH   = $bits(icache_cfg_pkg::addr_t) - INDEX_WIDTH - OFFSET_WIDTH
) (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       capture,
    input  icache_op_pkg::fetch_req_t  req,
    output logic [TAG_WIDTH-1:0]       buf_tag,
    output logic [INDEX_WIDTH-1:0]     buf_index,
    output logic                       buf_way,
    output logic                       buf_uncached,
    output logic                       buf_is_op,
    output icache_op_pkg::cacop_kind_e buf_kind,
    output icache_cfg_pkg::addr_t      buf_addr
);
    import icache_op_pkg::*;

    cacop_kind_e kind_d;  // kind of the incoming opcode

    //////////////////////////////////////////////////
    // opcode decode

    always_comb begin
        if (req.opcode[31]) begin
            kind_d = OP_IBAR;  // barrier wins over the low field
        end else begin
            case (req.opcode[4:3])
                2'd0:    kind_d = OP_IDX_INIT;
                2'd1:    kind_d = OP_IDX_INV;
                2'd2:    kind_d = OP_HIT_INV;
                default: kind_d = OP_NONE;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // request buffer

    // flags that steer the state machine
    always_ff @(posedge clk) begin
        if (!rstn) begin
            buf_is_op    <= 1'b0;
            buf_uncached <= 1'b0;
            buf_kind     <= OP_NONE;
        end else if (capture) begin
            buf_is_op    <= req.is_op;
            buf_uncached <= req.uncached;
            buf_kind     <= kind_d;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            buf_addr <= req.addr;
        end
    end

    // address split, offset bits are dropped
    assign buf_tag   = buf_addr[INDEX_WIDTH+OFFSET_WIDTH +: TAG_WIDTH];
    assign buf_index = buf_addr[OFFSET_WIDTH +: INDEX_WIDTH];
    assign buf_way   = buf_addr[0];  // way select for index ops

endmodule

`default_nettype wire

// File: hw/icache_tagv_array.sv
`timescale 1ns/1ps
`default_nettype none

module icache_tagv_array #(
    parameter int INDEX_WIDTH  = icache_cfg_pkg::INDEX_WIDTH,
    parameter int OFFSET_WIDTH = icache_cfg_pkg::OFFSET_WIDTH,
    localparam int TAG_WIDTH   = $bits(icache_cfg_pkg::addr_t) - INDEX_WIDTH - OFFSET_WIDTH
) (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic [TAG_WIDTH-1:0]     tag,
    input  logic [INDEX_WIDTH-1:0]   index,
    input  icache_op_pkg::tagv_cmd_t cmd,
    output logic [1:0]               hit
);
    localparam int SETS = 1 << INDEX_WIDTH;

    typedef logic [TAG_WIDTH-1:0] tag_t;

    tag_t                 tags [2][SETS];
    logic [1:0][SETS-1:0] valid;       // per way, per set
    logic [1:0]           init_mask;   // way named by index init
    logic [1:0]           clear_mask;  // ways losing valid at the index

    assign init_mask  = cmd.init_en ? {cmd.init_way, ~cmd.init_way} : 2'b00;
    assign clear_mask = cmd.inval | init_mask;

    //////////////////////////////////////////////////
    // valid bits

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid <= '0;
        end else if (cmd.ibar) begin
            valid <= '0;  // barrier drops the whole cache
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (cmd.fill_way_we[w]) begin
                    valid[w][index] <= 1'b1;
                end else if (clear_mask[w]) begin
                    valid[w][index] <= 1'b0;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // tags

    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (cmd.fill_way_we[w]) begin
                tags[w][index] <= tag;
            end else if (init_mask[w]) begin
                tags[w][index] <= '0;  // index init also wipes the tag
            end
        end
    end

    // compare against the buffered request, no register
    always_comb begin
        for (int w = 0; w < 2; w++) begin
            hit[w] = valid[w][index] && (tags[w][index] == tag);
        end
    end

endmodule

`default_nettype wire

// File: hw/icache_way_store.sv
`timescale 1ns/1ps
`default_nettype none

module icache_way_store #(
    parameter int INDEX_WIDTH = icache_cfg_pkg::INDEX_WIDTH
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic [INDEX_WIDTH-1:0] index,
    input  logic [1:0]             data_we,
    input  icache_cfg_pkg::word_t  wdata,
    input  logic                   lru_use0,
    input  logic                   lru_use1,
    output icache_cfg_pkg::word_t  way0_word,
    output icache_cfg_pkg::word_t  way1_word,
    output logic                   victim
);
    import icache_cfg_pkg::*;

    localparam int SETS = 1 << INDEX_WIDTH;

    word_t           data_mem [2][SETS];
    logic [SETS-1:0] lru;  // 1 means way 1 is the older one

    //////////////////////////////////////////////////
    // data ways

    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (data_we[w]) begin
                data_mem[w][index] <= wdata;
            end
        end
    end

    assign way0_word = data_mem[0][index];
    assign way1_word = data_mem[1][index];

    //////////////////////////////////////////////////
    // replacement

    always_ff @(posedge clk) begin
        if (!rstn) begin
            lru <= '0;
        end else if (lru_use0) begin
            lru[index] <= 1'b1;  // way 0 just used
        end else if (lru_use1) begin
            lru[index] <= 1'b0;
        end
    end

    assign victim = lru[index];

endmodule

`default_nettype wire

// File: hw/icache_main_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module icache_main_fsm (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       req_valid,
    input  icache_op_pkg::pipe_ctrl_t  ctrl,
    input  logic [1:0]                 hit,
    input  logic                       uncached,
    input  logic                       is_op,
    input  icache_op_pkg::cacop_kind_e kind,
    input  logic                       way,
    input  logic                       victim,
    input  logic                       mem_data_ok,
    output logic                       ready,
    output logic                       capture,
    output logic                       mem_req,
    output logic                       op_ack,
    output icache_op_pkg::tagv_cmd_t   tagv_cmd,
    output logic [1:0]                 data_we,
    output logic                       lru_use0,
    output logic                       lru_use1,
    output logic                       choose_way,
    output logic                       return_refill,
    output logic                       resp_en
);
    import icache_op_pkg::*;

    fsm_state_e state_q;     // registered
    fsm_state_e state;       // what this cycle acts on
    fsm_state_e state_hold;  // next state when nothing is accepted
    fsm_state_e state_d;
    logic       rstn_q;
    logic       can_take;    // machine could take a request now
    logic       miss;
    logic [1:0] hit_way;     // one hot, way 0 first

    always_ff @(posedge clk) begin
        rstn_q <= rstn;  // keeps ready low for one cycle out of reset
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // an accepted request lands in lookup, the buffered flag makes it an op
    assign state   = (state_q == ST_LOOKUP && is_op) ? ST_OPERATION : state_q;
    assign miss    = ~|hit | uncached;  // uncached always goes out
    assign hit_way = hit[0] ? 2'b01 : {hit[1], 1'b0};

    assign ready   = can_take & ~ctrl.stall & rstn_q;
    assign capture = req_valid & ready;
    assign state_d = capture ? ST_LOOKUP : state_hold;

    //////////////////////////////////////////////////
    // outputs and next state

    always_comb begin
        state_hold    = state_q;
        can_take      = 1'b0;
        mem_req       = 1'b0;
        op_ack        = 1'b0;
        resp_en       = 1'b0;
        return_refill = 1'b0;
        choose_way    = hit_way[1];
        data_we       = 2'b00;
        lru_use0      = 1'b0;
        lru_use1      = 1'b0;
        tagv_cmd      = '0;
        case (state)
            ST_IDLE: begin
                can_take = 1'b1;
            end
            ST_LOOKUP: begin
                if (ctrl.flush) begin
                    state_hold = ST_FLUSH;  // drop it, nothing goes out
                end else if (miss) begin
                    mem_req        = 1'b1;
                    state_hold     = ST_MISS_WAIT;
                    tagv_cmd.inval = uncached ? hit_way : 2'b00;
                end else begin
                    can_take   = 1'b1;
                    resp_en    = 1'b1;
                    lru_use0   = hit_way[0];
                    lru_use1   = hit_way[1];
                    state_hold = ST_IDLE;
                end
            end
            ST_MISS_WAIT: begin
                mem_req = 1'b1;  // held through the data cycle
                if (mem_data_ok) begin
                    can_take      = 1'b1;
                    resp_en       = 1'b1;
                    return_refill = 1'b1;
                    state_hold    = ST_IDLE;
                    if (!uncached) begin
                        data_we              = victim ? 2'b10 : 2'b01;
                        tagv_cmd.fill_way_we = victim ? 2'b10 : 2'b01;
                        lru_use0             = ~victim;
                        lru_use1             = victim;
                    end
                end
            end
            ST_OPERATION: begin
                if (ctrl.flush) begin
                    state_hold = ST_FLUSH;
                end else begin
                    can_take   = 1'b1;
                    op_ack     = 1'b1;
                    state_hold = ST_IDLE;
                    case (kind)
                        OP_IDX_INIT: begin
                            tagv_cmd.init_en  = 1'b1;
                            tagv_cmd.init_way = way;
                        end
                        OP_IDX_INV: tagv_cmd.inval = way ? 2'b10 : 2'b01;
                        OP_HIT_INV: tagv_cmd.inval = hit_way;
                        OP_IBAR:    tagv_cmd.ibar  = 1'b1;
                        default:    ;  // reserved field, ack only
                    endcase
                end
            end
            ST_FLUSH: begin
                if (!ctrl.flush) begin
                    state_hold = ST_IDLE;
                end
            end
            default: begin
                state_hold = ST_IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hw/icache_return_mux.sv
`timescale 1ns/1ps
`default_nettype none

module icache_return_mux (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  resp_en,
    input  logic                  choose_way,
    input  logic                  return_refill,
    input  icache_cfg_pkg::word_t way0_word,
    input  icache_cfg_pkg::word_t way1_word,
    input  icache_cfg_pkg::word_t mem_rdata,
    output icache_cfg_pkg::word_t rdata,
    output logic                  rdata_valid
);
    import icache_cfg_pkg::*;

    word_t sel_word;
    word_t last_q;  // last word handed to the pipeline

    always_comb begin
        if (return_refill) begin
            sel_word = mem_rdata;  // bypass on refill and uncached
        end else if (choose_way) begin
            sel_word = way1_word;
        end else begin
            sel_word = way0_word;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            last_q <= '0;
        end else if (resp_en) begin
            last_q <= sel_word;
        end
    end

    // the pipeline sees the old word until the next response
    assign rdata       = resp_en ? sel_word : last_q;
    assign rdata_valid = resp_en;

endmodule

`default_nettype wire

// File: hw/icache_top.sv
`timescale 1ns/1ps
`default_nettype none

module icache_top #(
    parameter int INDEX_WIDTH  = icache_cfg_pkg::INDEX_WIDTH,
    parameter int OFFSET_WIDTH = icache_cfg_pkg::OFFSET_WIDTH
) (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      req_valid,
    input  icache_op_pkg::fetch_req_t req,
    input  icache_op_pkg::pipe_ctrl_t ctrl,
    output logic                      ready,
    output logic                      rdata_valid,
    output icache_cfg_pkg::word_t     rdata,
    output logic                      op_ack,
    output logic                      mem_req,
    output icache_cfg_pkg::addr_t     mem_addr,
    input  logic                      mem_data_ok,
    input  icache_cfg_pkg::word_t     mem_rdata
);
    import icache_cfg_pkg::*;
    import icache_op_pkg::*;

    localparam int TAG_WIDTH = $bits(addr_t) - INDEX_WIDTH - OFFSET_WIDTH;

    //////////////////////////////////////////////////
    // internal nets

    logic [TAG_WIDTH-1:0]   buf_tag;
    logic [INDEX_WIDTH-1:0] buf_index;
    logic                   buf_way, buf_uncached, buf_is_op;
    cacop_kind_e            buf_kind;
    addr_t                  buf_addr;
    logic                   capture;
    logic [1:0]             hit;
    logic [1:0]             data_we;
    tagv_cmd_t              tagv_cmd;
    logic                   lru_use0, lru_use1, victim;
    logic                   choose_way, return_refill, resp_en;
    word_t                  way0_word, way1_word;

    assign mem_addr = buf_addr;  // stable while the miss waits

    icache_req_decode #(.INDEX_WIDTH(INDEX_WIDTH), .OFFSET_WIDTH(OFFSET_WIDTH)) u_decode (
        .clk, .rstn, .capture, .req, .buf_tag, .buf_index, .buf_way,
        .buf_uncached, .buf_is_op, .buf_kind, .buf_addr
    );

    icache_tagv_array #(.INDEX_WIDTH(INDEX_WIDTH), .OFFSET_WIDTH(OFFSET_WIDTH)) u_tagv (
        .clk, .rstn, .tag(buf_tag), .index(buf_index), .cmd(tagv_cmd), .hit
    );

    icache_way_store #(.INDEX_WIDTH(INDEX_WIDTH)) u_ways (
        .clk, .rstn, .index(buf_index), .data_we, .wdata(mem_rdata),
        .lru_use0, .lru_use1, .way0_word, .way1_word, .victim
    );

    icache_main_fsm u_fsm (
        .clk, .rstn, .req_valid, .ctrl, .hit, .uncached(buf_uncached),
        .is_op(buf_is_op), .kind(buf_kind), .way(buf_way), .victim, .mem_data_ok,
        .ready, .capture, .mem_req, .op_ack, .tagv_cmd, .data_we,
        .lru_use0, .lru_use1, .choose_way, .return_refill, .resp_en
    );

    icache_return_mux u_ret (
        .clk, .rstn, .resp_en, .choose_way, .return_refill,
        .way0_word, .way1_word, .mem_rdata, .rdata, .rdata_valid
    );

endmodule

`default_nettype wire

// File: verification/icache_properties.sv
`timescale 1ns/1ps
`default_nettype none

module icache_properties (
    input logic clk,
    input logic rstn,
    input logic mem_req,
    input logic mem_data_ok,
    input logic op_ack,
    input logic resp_en
);
    int fail_count = 0;  // read by the testbench at the end of the run

    //////////////////////////////////////////////////
    // state machine output rules

    a_req_not_ack: assert property (@(posedge clk) disable iff (!rstn)
        !(mem_req && op_ack))
        else begin
            $error("mem_req and op_ack high in the same cycle");
            fail_count++;
        end

    // miss request held until the data pulse
    a_req_held: assert property (@(posedge clk) disable iff (!rstn)
        (mem_req && !mem_data_ok) |=> mem_req)
        else begin
            $error("mem_req dropped before mem_data_ok");
            fail_count++;
        end

    a_resp_not_ack: assert property (@(posedge clk) disable iff (!rstn)
        !(resp_en && op_ack))
        else begin
            $error("rdata_valid and op_ack high in the same cycle");
            fail_count++;
        end

endmodule

bind icache_main_fsm icache_properties u_props (
    .clk, .rstn, .mem_req, .mem_data_ok, .op_ack, .resp_en
);

`default_nettype wire

// File: verification/icache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module icache_tb;
    import icache_cfg_pkg::*;
    import icache_op_pkg::*;

    localparam int    IDX_W        = 4;
    localparam int    OFS_W        = 2;
    localparam int    TAG_W        = 32 - IDX_W - OFS_W;
    localparam int    SETS         = 1 << IDX_W;
    localparam int    MAX_CYCLES   = 3000;  // ~50 transactions of at most 12 cycles, wide margin
    localparam word_t DATA_MASK    = 32'h5A5A_0000;
    localparam word_t OPC_IDX_INIT = 32'h0000_0000;
    localparam word_t OPC_IDX_INV  = 32'h0000_0008;  // bits 4:3 = 1
    localparam word_t OPC_HIT_INV  = 32'h0000_0010;
    localparam word_t OPC_IBAR     = 32'h8000_0000;

    logic       clk;
    logic       rstn;
    logic       req_valid;
    fetch_req_t req;
    pipe_ctrl_t ctrl;
    logic       ready, rdata_valid, op_ack, mem_req, mem_data_ok;
    word_t      rdata, mem_rdata;
    addr_t      mem_addr;
    int         cycle_count = 0;
    int         mem_req_count;

    // reference copy of tags, valid bits and LRU
    logic             m_valid [2][SETS];
    logic [TAG_W-1:0] m_tag [2][SETS];
    logic             m_lru [SETS];

    icache_top #(.INDEX_WIDTH(IDX_W), .OFFSET_WIDTH(OFS_W)) dut (
        .clk, .rstn, .req_valid, .req, .ctrl, .ready, .rdata_valid, .rdata, .op_ack,
        .mem_req, .mem_addr, .mem_data_ok, .mem_rdata
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Regression failed");
            $fatal(1, "timeout after %0d cycles without finishing the tests", MAX_CYCLES);
        end
    end

    // a failed state machine property ends the run
    always @(posedge clk) begin
        if (dut.u_fsm.u_props.fail_count != 0) begin
            $display("Regression failed");
            $fatal(1, "a state machine property failed");
        end
    end

    //////////////////////////////////////////////////
    // memory responder, 1 to 5 cycles per request

    initial begin : mem_responder
        addr_t addr;
        int    delay;
        mem_data_ok   = 1'b0;
        mem_rdata     = '0;
        mem_req_count = 0;
        void'($urandom(55911));
        forever begin
            @(negedge clk);
            if (rstn && mem_req) begin
                mem_req_count++;
                addr  = mem_addr;
                delay = $urandom % 5 + 1;
                repeat (delay) @(posedge clk);
                #1;
                mem_data_ok = 1'b1;
                mem_rdata   = addr ^ DATA_MASK;
                @(posedge clk);
                #1;
                mem_data_ok = 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////
    // helpers

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic report_error(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        $display("Regression failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string what, input word_t got, input word_t exp);
        assert (got === exp)
            else report_error($sformatf("%s is %h, expected %h", what, got, exp));
    endtask

    function automatic addr_t make_addr(input logic [TAG_W-1:0] tag,
                                        input logic [IDX_W-1:0] idx);
        return {tag, idx, 2'b00};
    endfunction

    function automatic int set_of(input addr_t a);
        return int'(a[OFS_W +: IDX_W]);
    endfunction

    function automatic int model_hit_way(input addr_t a);
        int s;
        s = set_of(a);
        for (int w = 0; w < 2; w++) begin
            if (m_valid[w][s] && m_tag[w][s] == a[31 -: TAG_W]) begin
                return w;
            end
        end
        return -1;
    endfunction

    // drives a request and returns in the cycle after its accept
    task automatic issue(input addr_t a, input logic is_op, input word_t opcode, input logic unc);
        next_cycle();
        req.addr     = a;
        req.is_op    = is_op;
        req.opcode   = opcode;
        req.uncached = unc;
        req_valid    = 1'b1;
        @(negedge clk);
        while (!ready) begin
            @(negedge clk);
        end
        next_cycle();
        req_valid = 1'b0;
    endtask

    task automatic fetch_check(input addr_t a, input logic unc);
        int s;
        int hw;
        int v;
        int count0;
        s  = set_of(a);
        hw = model_hit_way(a);
        issue(a, 1'b0, '0, unc);
        count0 = mem_req_count;
        @(negedge clk);
        if (!unc && hw >= 0) begin
            check_value("rdata_valid one cycle after hit accept", rdata_valid, 1);
            check_value("mem_req on hit", mem_req, 0);
            check_value("hit rdata", rdata, a ^ DATA_MASK);
            m_lru[s] = (hw == 0);
        end else begin
            check_value("mem_req one cycle after miss accept", mem_req, 1);
            check_value("mem_addr on miss", mem_addr, a);
            check_value("rdata_valid in miss lookup", rdata_valid, 0);
            while (!rdata_valid) begin
                @(negedge clk);
            end
            check_value("mem_data_ok with refill response", mem_data_ok, 1);
            check_value("refill rdata", rdata, a ^ DATA_MASK);
            check_value("memory requests for one miss", mem_req_count, count0 + 1);
            if (unc) begin
                if (hw >= 0) begin
                    m_valid[hw][s] = 1'b0;
                end
            end else begin
                v = int'(m_lru[s]);
                m_valid[v][s] = 1'b1;
                m_tag[v][s]   = a[31 -: TAG_W];
                m_lru[s]      = (v == 0);
            end
        end
    endtask

    task automatic cache_op(input addr_t a, input word_t opcode);
        int s;
        int hw;
        s  = set_of(a);
        hw = model_hit_way(a);
        issue(a, 1'b1, opcode, 1'b0);
        @(negedge clk);
        check_value("op_ack one cycle after accept", op_ack, 1);
        check_value("rdata_valid on cache op", rdata_valid, 0);
        check_value("mem_req on cache op", mem_req, 0);
        if (opcode[31]) begin
            for (int i = 0; i < SETS; i++) begin
                m_valid[0][i] = 1'b0;
                m_valid[1][i] = 1'b0;
            end
        end else if (opcode[4:3] == 2'd0 || opcode[4:3] == 2'd1) begin
            m_valid[int'(a[0])][s] = 1'b0;  // index ops pick the way by address bit 0
        end else if (opcode[4:3] == 2'd2 && hw >= 0) begin
            m_valid[hw][s] = 1'b0;
        end
    endtask

    // flush in the lookup cycle, nothing may come out
    task automatic flushed_fetch(input addr_t a);
        int count0;
        issue(a, 1'b0, '0, 1'b0);
        count0     = mem_req_count;
        ctrl.flush = 1'b1;
        @(negedge clk);
        check_value("rdata_valid under flush", rdata_valid, 0);
        check_value("mem_req under flush", mem_req, 0);
        next_cycle();
        @(negedge clk);
        check_value("ready while flush high", ready, 0);
        next_cycle();
        ctrl.flush = 1'b0;
        check_value("memory requests after flush", mem_req_count, count0);
    endtask

    //////////////////////////////////////////////////
    // tests

    task automatic test_reset();
        for (int i = 0; i < SETS; i++) begin
            m_valid[0][i] = 1'b0;
            m_valid[1][i] = 1'b0;
            m_tag[0][i]   = '0;
            m_tag[1][i]   = '0;
            m_lru[i]      = 1'b0;
        end
        repeat (2) @(posedge clk);
        #1;
        rstn = 1'b1;
        @(negedge clk);
        check_value("ready after reset", ready, 0);
        check_value("mem_req after reset", mem_req, 0);
        check_value("rdata_valid after reset", rdata_valid, 0);
        check_value("op_ack after reset", op_ack, 0);
    endtask

    task automatic test_miss_hit();
        fetch_check(make_addr(26'h0123, 4'h3), 1'b0);
        fetch_check(make_addr(26'h0123, 4'h3), 1'b0);
    endtask

    task automatic test_lru();
        fetch_check(make_addr(26'h10, 4'h5), 1'b0);  // A
        fetch_check(make_addr(26'h20, 4'h5), 1'b0);  // B
        fetch_check(make_addr(26'h10, 4'h5), 1'b0);
        fetch_check(make_addr(26'h30, 4'h5), 1'b0);  // C takes B's way
        fetch_check(make_addr(26'h10, 4'h5), 1'b0);
        fetch_check(make_addr(26'h20, 4'h5), 1'b0);
    endtask

    task automatic test_uncached();
        fetch_check(make_addr(26'h44, 4'h7), 1'b0);
        fetch_check(make_addr(26'h44, 4'h7), 1'b0);
        fetch_check(make_addr(26'h44, 4'h7), 1'b1);  // drops the cached copy
        fetch_check(make_addr(26'h44, 4'h7), 1'b1);
        fetch_check(make_addr(26'h44, 4'h7), 1'b0);
    endtask

    task automatic test_cache_ops();
        fetch_check(make_addr(26'h50, 4'h9), 1'b0);
        fetch_check(make_addr(26'h51, 4'h9), 1'b0);
        cache_op(make_addr(26'h0, 4'h9) | 32'h1, OPC_IDX_INV);
        fetch_check(make_addr(26'h50, 4'h9), 1'b0);
        fetch_check(make_addr(26'h51, 4'h9), 1'b0);
        cache_op(make_addr(26'h0, 4'h9), OPC_IDX_INIT);
        fetch_check(make_addr(26'h50, 4'h9), 1'b0);
        fetch_check(make_addr(26'h51, 4'h9), 1'b0);
        cache_op(make_addr(26'h51, 4'h9), OPC_HIT_INV);
        fetch_check(make_addr(26'h51, 4'h9), 1'b0);
        cache_op(make_addr(26'h0, 4'h0), OPC_IBAR);
        fetch_check(make_addr(26'h50, 4'h9), 1'b0);
        fetch_check(make_addr(26'h10, 4'h5), 1'b0);
        fetch_check(make_addr(26'h0123, 4'h3), 1'b0);
    endtask

    task automatic test_stall_flush();
        addr_t a;
        a = make_addr(26'h0123, 4'h3);
        next_cycle();
        ctrl.stall = 1'b1;
        req.addr   = a;
        req_valid  = 1'b1;
        repeat (4) begin
            @(negedge clk);
            check_value("ready while stalled", ready, 0);
            next_cycle();
        end
        ctrl.stall = 1'b0;
        req_valid  = 1'b0;
        // a hit already in lookup still answers under stall
        issue(a, 1'b0, '0, 1'b0);
        ctrl.stall = 1'b1;
        @(negedge clk);
        check_value("rdata_valid under stall", rdata_valid, 1);
        check_value("ready under stall", ready, 0);
        check_value("rdata under stall", rdata, a ^ DATA_MASK);
        m_lru[set_of(a)] = (model_hit_way(a) == 0);
        next_cycle();
        ctrl.stall = 1'b0;
        flushed_fetch(a);
        fetch_check(a, 1'b0);
        flushed_fetch(make_addr(26'h77, 4'hC));
        fetch_check(make_addr(26'h77, 4'hC), 1'b0);
    endtask

    initial begin
        rstn      = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        ctrl      = '0;
        test_reset();
        test_miss_hit();
        test_lru();
        test_uncached();
        test_cache_ops();
        test_stall_flush();
        repeat (3) next_cycle();
        if (dut.u_fsm.u_props.fail_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
hw/icache_cfg_pkg.sv
hw/icache_op_pkg.sv
hw/icache_req_decode.sv
hw/icache_tagv_array.sv
hw/icache_way_store.sv
hw/icache_main_fsm.sv
hw/icache_return_mux.sv
hw/icache_top.sv
verification/icache_properties.sv
verification/icache_tb.sv
